// File: bench/tb_exec_cluster.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module tb_exec_cluster;
    import exec_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_RANDOM   = 200;
    // opcode sweep, full-station sequence, random traffic
    localparam int TOTAL_OPS    = 10 + 8 + NUM_RANDOM;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + 40 * TOTAL_OPS) * CLK_PERIOD;
    localparam int TAGS         = 1 << `ROB_TAG_W;
    localparam int FULL_LIMIT   = 20;

    logic     clk;
    logic     rst_n_i;
    logic     flush_i;
    logic     dispatch_valid_i;
    alu_op_e  dispatch_op_i;
    logic     dispatch_src1_ready_i;
    logic     dispatch_src2_ready_i;
    rob_tag_t dispatch_src1_tag_i;
    rob_tag_t dispatch_src2_tag_i;
    word_t    dispatch_src1_value_i;
    word_t    dispatch_src2_value_i;
    rob_tag_t dispatch_tag_i;
    logic     rs_full_o;
    logic     cdb_valid_o;
    rob_tag_t cdb_tag_o;
    word_t    cdb_value_o;

    // rob model: tags in flight and the result each one must broadcast
    logic [TAGS-1:0] live;
    word_t           exp_val [TAGS];
    rob_tag_t        next_tag;
    rob_tag_t        last_tag;
    integer          seed;
    int              full_cycles;
    logic            saw_full;
    logic            saw_stall;
    logic            quick_accept;

    exec_cluster uut (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .flush_i               (flush_i),
        .dispatch_valid_i      (dispatch_valid_i),
        .dispatch_op_i         (dispatch_op_i),
        .dispatch_src1_ready_i (dispatch_src1_ready_i),
        .dispatch_src2_ready_i (dispatch_src2_ready_i),
        .dispatch_src1_tag_i   (dispatch_src1_tag_i),
        .dispatch_src2_tag_i   (dispatch_src2_tag_i),
        .dispatch_src1_value_i (dispatch_src1_value_i),
        .dispatch_src2_value_i (dispatch_src2_value_i),
        .dispatch_tag_i        (dispatch_tag_i),
        .rs_full_o             (rs_full_o),
        .cdb_valid_o           (cdb_valid_o),
        .cdb_tag_o             (cdb_tag_o),
        .cdb_value_o           (cdb_value_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    // rv32i result worked out from the instruction rules
    function automatic word_t ref_alu(alu_op_e op, word_t a, word_t b);
        int unsigned sh;
        word_t       fill;
        sh = b[4:0];
        fill = a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0;
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 1;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | fill;
            // signs differ, the negative one is smaller
            ALU_SLT:  return (a[`XLEN-1] != b[`XLEN-1]) ? word_t'(a[`XLEN-1]) : word_t'(a < b);
            ALU_SLTU: return word_t'(a < b);
            default:  return '0;
        endcase
    endfunction

    // model bookkeeping at each rising edge
    always @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            live = '0;
        end else if (cdb_valid_o) begin
            live[cdb_tag_o] = 1'b0;
        end
        full_cycles = (rs_full_o === 1'b1) ? full_cycles + 1 : 0;
        if (rs_full_o === 1'b1) begin
            saw_full = 1'b1;
        end
        if (uut.stall1 === 1'b1) begin
            saw_stall = 1'b1;
        end
    end

    // ready dispatch taken while nothing else is in flight
    assign quick_accept = dispatch_valid_i && !rs_full_o && dispatch_src1_ready_i
                          && dispatch_src2_ready_i && (live == '0);

    a_cdb_value: assert property (@(posedge clk) disable iff (!rst_n_i)
        cdb_valid_o |-> cdb_value_o == exp_val[cdb_tag_o])
        else report_error($sformatf("mismatch at %0t: cdb_value_o = 0x%08h, expected 0x%08h",
                                    $time, $sampled(cdb_value_o),
                                    exp_val[$sampled(cdb_tag_o)]));

    // each tag goes out once, and only while it is outstanding
    a_cdb_tag_live: assert property (@(posedge clk) disable iff (!rst_n_i)
        cdb_valid_o |-> live[cdb_tag_o])
        else report_error($sformatf("broadcast of tag %0d at %0t which is not outstanding",
                                    $sampled(cdb_tag_o), $time));

    a_idle_latency: assert property (@(posedge clk) disable iff (!rst_n_i || flush_i)
        quick_accept |-> ##2 (cdb_valid_o && cdb_tag_o == $past(dispatch_tag_i, 2)))
        else report_error($sformatf("op into an idle cluster missed the 2-cycle broadcast at %0t",
                                    $time));

    a_full_releases: assert property (@(posedge clk) disable iff (!rst_n_i)
        rs_full_o |-> full_cycles < FULL_LIMIT)
        else report_error("station stayed full and never woke up");

    a_clear_after_flush: assert property (@(posedge clk)
        (!rst_n_i || flush_i) |=> !cdb_valid_o && !rs_full_o)
        else report_error("broadcast or full flag still set right after reset or flush");

    // drive one op until accepted, sources resolved against the model each cycle
    task automatic send_op(input alu_op_e op, input int dep1, input int dep2,
                           input word_t v1, input word_t v2);
        word_t    a;
        word_t    b;
        rob_tag_t dest;
        logic     accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            dispatch_valid_i = 1'b0;
            if (live != '1) begin
                while (live[next_tag]) begin
                    next_tag = next_tag + 1'b1;
                end
                dest = next_tag;
                a = (dep1 < 0) ? v1 : exp_val[dep1];
                b = (dep2 < 0) ? v2 : exp_val[dep2];
                // wait on the tag only while its producer is still in flight
                dispatch_src1_ready_i = (dep1 < 0) || !live[dep1];
                dispatch_src2_ready_i = (dep2 < 0) || !live[dep2];
                dispatch_src1_tag_i   = rob_tag_t'((dep1 < 0) ? 0 : dep1);
                dispatch_src2_tag_i   = rob_tag_t'((dep2 < 0) ? 0 : dep2);
                // junk value on a waiting source
                dispatch_src1_value_i = dispatch_src1_ready_i ? a : ~a;
                dispatch_src2_value_i = dispatch_src2_ready_i ? b : ~b;
                dispatch_op_i         = op;
                dispatch_tag_i        = dest;
                dispatch_valid_i      = 1'b1;
                // full only moves on the rising edge
                accepted = !rs_full_o;
                @(posedge clk);
                if (accepted) begin
                    live[dest]    = 1'b1;
                    exp_val[dest] = ref_alu(op, a, b);
                    last_tag      = dest;
                    next_tag      = dest + 1'b1;
                end
            end
        end
    endtask

    task automatic random_op();
        alu_op_e op;
        int      d1;
        int      d2;
        word_t   v1;
        word_t   v2;
        op = alu_op_e'($unsigned($random(seed)) % 10);
        // roughly half the sources hang off an earlier tag
        d1 = ($random(seed) & 1) ? int'($unsigned($random(seed)) % TAGS) : -1;
        d2 = ($random(seed) & 1) ? int'($unsigned($random(seed)) % TAGS) : -1;
        v1 = $random(seed);
        v2 = ($random(seed) & 1) ? word_t'($unsigned($random(seed)) % 40) : $random(seed);
        send_op(op, d1, d2, v1, v2);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        dispatch_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        @(negedge clk);
        dispatch_valid_i = 1'b0;
        while (live != '0) begin
            @(negedge clk);
        end
    endtask

    task automatic pulse_flush();
        @(negedge clk);
        dispatch_valid_i = 1'b0;
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_error("timeout: results were still outstanding when the watchdog expired");
    end

    initial begin
        rob_tag_t chain;
        seed                  = 46;
        rst_n_i               = 1'b0;
        flush_i               = 1'b0;
        dispatch_valid_i      = 1'b0;
        dispatch_op_i         = ALU_ADD;
        dispatch_src1_ready_i = 1'b0;
        dispatch_src2_ready_i = 1'b0;
        dispatch_src1_tag_i   = '0;
        dispatch_src2_tag_i   = '0;
        dispatch_src1_value_i = '0;
        dispatch_src2_value_i = '0;
        dispatch_tag_i        = '0;
        live                  = '0;
        next_tag              = '0;
        last_tag              = '0;
        full_cycles           = 0;
        saw_full              = 1'b0;
        saw_stall             = 1'b0;
        for (int t = 0; t < TAGS; t++) begin
            exp_val[t] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        // each opcode alone in an idle cluster
        for (int k = 0; k < 10; k++) begin
            wait_drain();
            send_op(alu_op_e'(k), -1, -1, $random(seed), $random(seed));
        end

        // dependency chain slows the producer so its consumers fill the station
        wait_drain();
        send_op(ALU_ADD, -1, -1, 32'd5, 32'd7);
        for (int k = 0; k < 3; k++) begin
            send_op(ALU_XOR, int'(last_tag), -1, '0, 32'h1 << k);
        end
        chain = last_tag;
        for (int k = 0; k < 4; k++) begin
            send_op(ALU_SUB, int'(chain), -1, '0, word_t'(k + 1));
        end

        // random traffic with a flush halfway through
        for (int k = 0; k < NUM_RANDOM; k++) begin
            if (k == NUM_RANDOM / 2) begin
                pulse_flush();
            end
            if (k % 50 == 49) begin
                wait_drain();
            end
            if (($random(seed) & 3) == 0) begin
                idle_cycle();
            end
            random_op();
        end
        wait_drain();
        repeat (4) @(negedge clk);

        if (!saw_full || !saw_stall) begin
            report_error("stimulus never filled the station or never stalled lane 1");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: design/alu.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module alu (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    issue_if.alu               issue_i,
    // arbiter lost this lane's result this cycle
    input  logic               stall_i,
    output logic               res_valid_o,
    output exec_pkg::rob_tag_t res_tag_o,
    output exec_pkg::word_t    res_value_o
);
    import exec_pkg::*;

    word_t                  result;
    logic [`SHAMT_W-1:0]    shamt;
    logic                   take;

    assign shamt = issue_i.b[`SHAMT_W-1:0];

    // rv32i integer result
    always_comb begin
        case (issue_i.op)
            ALU_ADD:  result = issue_i.a + issue_i.b;
            ALU_SUB:  result = issue_i.a - issue_i.b;
            ALU_AND:  result = issue_i.a & issue_i.b;
            ALU_OR:   result = issue_i.a | issue_i.b;
            ALU_XOR:  result = issue_i.a ^ issue_i.b;
            ALU_SLL:  result = issue_i.a << shamt;
            ALU_SRL:  result = issue_i.a >> shamt;
            ALU_SRA:  result = word_t'($signed(issue_i.a) >>> shamt);
            ALU_SLT:  result = word_t'($signed(issue_i.a) < $signed(issue_i.b));
            ALU_SLTU: result = word_t'(issue_i.a < issue_i.b);
            default:  result = '0;
        endcase
    end

    // blocked only while a held result is waiting for the cdb
    assign issue_i.ready = ~(res_valid_o & stall_i);
    assign take          = issue_i.valid & issue_i.ready;

    // result valid flag
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            res_valid_o <= 1'b0;
        end else if (take) begin
            res_valid_o <= 1'b1;
        end else if (!stall_i) begin
            // result went out on the cdb
            res_valid_o <= 1'b0;
        end
    end

    // result payload, only loaded on a transfer
    always_ff @(posedge clk) begin
        if (take) begin
            res_tag_o   <= issue_i.tag;
            res_value_o <= result;
        end
    end

    // a stalled result stays put until the arbiter lets it through
    a_hold_while_stalled: assert property (
        @(posedge clk) disable iff (!rst_n_i || flush_i)
        res_valid_o && stall_i |=> res_valid_o && $stable(res_tag_o) && $stable(res_value_o)
    );

endmodule

// File: design/alu_rs.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module alu_rs (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    // dispatch from rename
    input  logic               dispatch_valid_i,
    input  exec_pkg::alu_op_e  dispatch_op_i,
    input  logic               dispatch_src1_ready_i,
    input  logic               dispatch_src2_ready_i,
    input  exec_pkg::rob_tag_t dispatch_src1_tag_i,
    input  exec_pkg::rob_tag_t dispatch_src2_tag_i,
    input  exec_pkg::word_t    dispatch_src1_value_i,
    input  exec_pkg::word_t    dispatch_src2_value_i,
    input  exec_pkg::rob_tag_t dispatch_tag_i,
    // broadcast snoop
    input  logic               cdb_valid_i,
    input  exec_pkg::rob_tag_t cdb_tag_i,
    input  exec_pkg::word_t    cdb_value_i,
    output logic               rs_full_o,
    issue_if.station           issue0_o,
    issue_if.station           issue1_o
);
    import exec_pkg::*;

    localparam int N     = `RS_ENTRIES;
    localparam int IDX_W = `RS_IDX_W;

    typedef logic [N-1:0]     vec_t;
    typedef logic [IDX_W-1:0] idx_t;

    rs_entry_t entries [N];
    rs_entry_t disp_entry;

    vec_t busy_vec;
    vec_t rdy_vec;
    vec_t free_vec;
    vec_t disp_grant;
    vec_t cand0;
    vec_t cand1;
    vec_t grant0;
    vec_t grant1;
    vec_t xfer_vec;
    idx_t idx0;
    idx_t idx1;
    logic disp_accept;

    // pick up a broadcast value for an operand still waiting on its tag
    function automatic rs_operand_t snoop(rs_operand_t opnd, logic cv, rob_tag_t ct,
                                          word_t cd);
        rs_operand_t res;
        res = opnd;
        if (!opnd.ready && cv && (opnd.tag == ct)) begin
            res.ready = 1'b1;
            res.value = cd;
        end
        return res;
    endfunction

    // one-hot grant to a binary slot index
    function automatic idx_t onehot_to_idx(vec_t oh);
        idx_t idx;
        idx = '0;
        for (int i = 0; i < N; i++) begin
            if (oh[i]) begin
                idx = idx | idx_t'(i);
            end
        end
        return idx;
    endfunction

    // per-slot status flags
    always_comb begin
        for (int i = 0; i < N; i++) begin
            busy_vec[i] = entries[i].busy;
            rdy_vec[i]  = entries[i].busy & entries[i].src1.ready & entries[i].src2.ready;
        end
    end

    assign rs_full_o   = &busy_vec;
    assign disp_accept = dispatch_valid_i & ~rs_full_o;

    // lowest free slot takes the dispatch
    assign free_vec   = ~busy_vec;
    assign disp_grant = disp_accept ? (free_vec & (~free_vec + 1'b1)) : '0;

    // new entry, sources also snoop the cdb in the same cycle
    always_comb begin
        disp_entry.busy = 1'b1;
        disp_entry.op   = dispatch_op_i;
        disp_entry.dest = dispatch_tag_i;
        disp_entry.src1 = snoop('{dispatch_src1_ready_i, dispatch_src1_tag_i,
                                  dispatch_src1_value_i}, cdb_valid_i, cdb_tag_i, cdb_value_i);
        disp_entry.src2 = snoop('{dispatch_src2_ready_i, dispatch_src2_tag_i,
                                  dispatch_src2_value_i}, cdb_valid_i, cdb_tag_i, cdb_value_i);
    end

    // lane 0 takes the lowest ready slot when its alu can accept
    assign cand0  = issue0_o.ready ? rdy_vec : '0;
    assign grant0 = cand0 & (~cand0 + 1'b1);
    // lane 1 takes the lowest ready slot left over
    assign cand1  = issue1_o.ready ? (rdy_vec & ~grant0) : '0;
    assign grant1 = cand1 & (~cand1 + 1'b1);
    // a grant already implies ready, so it is a transfer
    assign xfer_vec = grant0 | grant1;

    assign idx0 = onehot_to_idx(grant0);
    assign idx1 = onehot_to_idx(grant1);

    assign issue0_o.valid = |grant0;
    assign issue0_o.op    = entries[idx0].op;
    assign issue0_o.a     = entries[idx0].src1.value;
    assign issue0_o.b     = entries[idx0].src2.value;
    assign issue0_o.tag   = entries[idx0].dest;

    assign issue1_o.valid = |grant1;
    assign issue1_o.op    = entries[idx1].op;
    assign issue1_o.a     = entries[idx1].src1.value;
    assign issue1_o.b     = entries[idx1].src2.value;
    assign issue1_o.tag   = entries[idx1].dest;

    // slot update: dispatch write, cdb wakeup, free on issue
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            for (int i = 0; i < N; i++) begin
                entries[i].busy <= 1'b0;
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (disp_grant[i]) begin
                    entries[i] <= disp_entry;
                end else if (entries[i].busy) begin
                    entries[i].src1 <= snoop(entries[i].src1, cdb_valid_i, cdb_tag_i,
                                             cdb_value_i);
                    entries[i].src2 <= snoop(entries[i].src2, cdb_valid_i, cdb_tag_i,
                                             cdb_value_i);
                    if (xfer_vec[i]) begin
                        entries[i].busy <= 1'b0;
                    end
                end
            end
        end
    end

    // a dispatch offered while full adds no slot, only issued slots leave
    a_no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        dispatch_valid_i && rs_full_o && !flush_i
        |=> $countones(busy_vec) == $past($countones(busy_vec) - $countones(xfer_vec))
    );

    // an offered op comes from a live slot with both sources resolved
    a_issue_operands_ready: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (issue0_o.valid |-> entries[idx0].busy && entries[idx0].src1.ready
                            && entries[idx0].src2.ready)
        and (issue1_o.valid |-> entries[idx1].busy && entries[idx1].src1.ready
                                && entries[idx1].src2.ready)
    );

    // both lanes never pull the same slot
    a_lanes_distinct: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        issue0_o.valid && issue1_o.valid |-> idx0 != idx1
    );

endmodule

// File: design/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter (
    // lane 0 result
    input  logic               res0_valid_i,
    input  exec_pkg::rob_tag_t res0_tag_i,
    input  exec_pkg::word_t    res0_value_i,
    // lane 1 result
    input  logic               res1_valid_i,
    input  exec_pkg::rob_tag_t res1_tag_i,
    input  exec_pkg::word_t    res1_value_i,
    // lane 1 must hold its result
    output logic               stall1_o,
    // single broadcast bus
    output logic               cdb_valid_o,
    output exec_pkg::rob_tag_t cdb_tag_o,
    output exec_pkg::word_t    cdb_value_o
);

    logic sel1;

    // fixed priority, lane 1 only goes when lane 0 is idle
    assign sel1 = ~res0_valid_i & res1_valid_i;

    // loser keeps its result for the next cycle
    assign stall1_o = res0_valid_i & res1_valid_i;

    // at most one result per cycle
    assign cdb_valid_o = res0_valid_i | res1_valid_i;
    assign cdb_tag_o   = sel1 ? res1_tag_i : res0_tag_i;
    assign cdb_value_o = sel1 ? res1_value_i : res0_value_i;

endmodule

// File: design/exec_cluster.sv
`timescale 1ns/1ps

module exec_cluster (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    // dispatch port
    input  logic               dispatch_valid_i,
    input  exec_pkg::alu_op_e  dispatch_op_i,
    input  logic               dispatch_src1_ready_i,
    input  logic               dispatch_src2_ready_i,
    input  exec_pkg::rob_tag_t dispatch_src1_tag_i,
    input  exec_pkg::rob_tag_t dispatch_src2_tag_i,
    input  exec_pkg::word_t    dispatch_src1_value_i,
    input  exec_pkg::word_t    dispatch_src2_value_i,
    input  exec_pkg::rob_tag_t dispatch_tag_i,
    output logic               rs_full_o,
    // common data bus
    output logic               cdb_valid_o,
    output exec_pkg::rob_tag_t cdb_tag_o,
    output exec_pkg::word_t    cdb_value_o
);
    import exec_pkg::*;

    // one issue lane per alu
    issue_if lane_if [2] ();

    logic [1:0] res_valid;
    rob_tag_t   res_tag [2];
    word_t      res_value [2];
    logic [1:0] lane_stall;
    logic       stall1;

    // lane 0 always wins arbitration
    assign lane_stall = {stall1, 1'b0};

    alu_rs u_rs (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .flush_i               (flush_i),
        .dispatch_valid_i      (dispatch_valid_i),
        .dispatch_op_i         (dispatch_op_i),
        .dispatch_src1_ready_i (dispatch_src1_ready_i),
        .dispatch_src2_ready_i (dispatch_src2_ready_i),
        .dispatch_src1_tag_i   (dispatch_src1_tag_i),
        .dispatch_src2_tag_i   (dispatch_src2_tag_i),
        .dispatch_src1_value_i (dispatch_src1_value_i),
        .dispatch_src2_value_i (dispatch_src2_value_i),
        .dispatch_tag_i        (dispatch_tag_i),
        // wakeup comes back from the broadcast bus
        .cdb_valid_i           (cdb_valid_o),
        .cdb_tag_i             (cdb_tag_o),
        .cdb_value_i           (cdb_value_o),
        .rs_full_o             (rs_full_o),
        .issue0_o              (lane_if[0]),
        .issue1_o              (lane_if[1])
    );

    for (genvar g = 0; g < 2; g++) begin : g_alu
        alu u_alu (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .issue_i     (lane_if[g]),
            .stall_i     (lane_stall[g]),
            .res_valid_o (res_valid[g]),
            .res_tag_o   (res_tag[g]),
            .res_value_o (res_value[g])
        );
    end

    cdb_arbiter u_arb (
        .res0_valid_i (res_valid[0]),
        .res0_tag_i   (res_tag[0]),
        .res0_value_i (res_value[0]),
        .res1_valid_i (res_valid[1]),
        .res1_tag_i   (res_tag[1]),
        .res1_value_i (res_value[1]),
        .stall1_o     (stall1),
        .cdb_valid_o  (cdb_valid_o),
        .cdb_tag_o    (cdb_tag_o),
        .cdb_value_o  (cdb_value_o)
    );

endmodule

// File: design/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// reservation station depth, power of two from 2 to 16
`define RS_ENTRIES 4

// index into the station, derived from the depth
`define RS_IDX_W $clog2(`RS_ENTRIES)

// rob tag width, 3 bits gives 8 rob entries
`define ROB_TAG_W 3

// rv32i data word
`define XLEN 32

// alu opcode field width
`define ALU_OP_W 4

// shift amount taken from the low bits of operand b
`define SHAMT_W 5

`endif

// File: design/exec_pkg.sv
`include "exec_config.svh"

package exec_pkg;

    // one data word
    typedef logic [`XLEN-1:0] word_t;

    // one rob tag
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // integer alu operations handled by the cluster
    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // source operand, either a known value or waiting on a tag
    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        word_t    value;
    } rs_operand_t;

    // one station slot
    typedef struct packed {
        logic        busy;
        alu_op_e     op;
        rs_operand_t src1;
        rs_operand_t src2;
        rob_tag_t    dest;
    } rs_entry_t;

endpackage

// File: design/issue_if.sv
`timescale 1ns/1ps

interface issue_if;
    import exec_pkg::*;

    // station offers an op with both operands known
    logic     valid;
    // alu can take an op this cycle
    logic     ready;
    alu_op_e  op;
    word_t    a;
    word_t    b;
    // destination rob tag travels with the op
    rob_tag_t tag;

    modport station (
        output valid,
        output op,
        output a,
        output b,
        output tag,
        input  ready
    );

    modport alu (
        input  valid,
        input  op,
        input  a,
        input  b,
        input  tag,
        output ready
    );

endinterface

// File: project.f
+incdir+design
design/exec_pkg.sv
design/issue_if.sv
design/alu_rs.sv
design/alu.sv
design/cdb_arbiter.sv
design/exec_cluster.sv
bench/tb_exec_cluster.sv
